/* compile.f */
+incdir+design
design/uart_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_loopback_top.sv
verification/uart_loopback_assert.sv
verification/uart_loopback_tb.sv

/* design/uart_loopback_top.sv */
`default_nettype none
`timescale 1ns/100ps

module uart_loopback_top (
	input  logic                      i_tx_clk,
	input  logic                      i_reset_tx,
	input  uart_pkg::uart_tx_req_t    i_tx_req,
	input  logic                      i_loopback,
	input  logic                      i_serial_in,
	output logic                      o_serial_out,
	output logic                      o_busy,
	output uart_pkg::uart_rx_result_t o_rx_result
);

	import uart_pkg::*;

	logic tx_line;  // transmitter output
	logic rx_line;  // receiver source after the select

	uart_tx u_tx (
		.i_tx_clk   (i_tx_clk),
		.i_reset_tx (i_reset_tx),
		.i_tx_req   (i_tx_req),
		.o_serial   (tx_line),
		.o_busy     (o_busy)
	);

	assign o_serial_out = tx_line;
	assign rx_line      = i_loopback ? tx_line : i_serial_in;  // loopback or external line

	uart_rx u_rx (
		.i_tx_clk    (i_tx_clk),
		.i_reset_tx  (i_reset_tx),
		.i_serial    (rx_line),
		.o_rx_result (o_rx_result)
	);

endmodule

`default_nettype wire

/* design/uart_macros.svh */
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// data bits carried by one frame
`define UART_DATA_WIDTH 8

// tx_clk cycles per serial bit, rx oversampling rate too
`define UART_CLOCKS_PER_BIT 8

// flops on the receive line before the rx fsm sees it
`define UART_SYNC_STAGES 3

// 1'b0 for even parity, 1'b1 for odd parity
`define UART_PARITY_ODD 1'b0

// start + data + parity + stop
`define UART_FRAME_BITS (`UART_DATA_WIDTH + 3)

`endif

/* design/uart_pkg.sv */
`default_nettype none

`include "uart_macros.svh"

package uart_pkg;

	typedef logic [`UART_DATA_WIDTH-1:0] uart_data_t;  // one payload byte

	// transmit request from the user side
	typedef struct packed {
		logic       send;  // single cycle strobe
		uart_data_t data;  // byte to serialize
	} uart_tx_req_t;

	// receive result, refreshed at every stop bit
	typedef struct packed {
		logic       valid;  // single cycle strobe
		logic       error;  // parity mismatch or low stop bit
		uart_data_t data;   // last received byte
	} uart_rx_result_t;

endpackage

`default_nettype wire

/* design/uart_rx.sv */
`default_nettype none
`timescale 1ns/100ps

`include "uart_macros.svh"

module uart_rx (
	input  logic                      i_tx_clk,
	input  logic                      i_reset_tx,
	input  logic                      i_serial,
	output uart_pkg::uart_rx_result_t o_rx_result
);

	import uart_pkg::*;

	localparam int unsigned BAUD_W = $clog2(`UART_CLOCKS_PER_BIT);  // oversample counter width
	localparam int unsigned IDX_W  = $clog2(`UART_DATA_WIDTH);      // data bit index width

	localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`UART_CLOCKS_PER_BIT - 1);
	localparam logic [BAUD_W-1:0] HALF_LAST = BAUD_W'(`UART_CLOCKS_PER_BIT / 2 - 1);
	localparam logic [IDX_W-1:0]  DATA_LAST = IDX_W'(`UART_DATA_WIDTH - 1);

	typedef enum logic [2:0] {
		RX_IDLE,    // waiting for a falling edge
		RX_START,   // counting to mid start bit
		RX_DATA,    // sampling data bits
		RX_PARITY,  // sampling the parity bit
		RX_STOP     // sampling the stop bit
	} rx_state_t;

	rx_state_t                    state;
	logic [`UART_SYNC_STAGES-1:0] sync_ff;     // metastability chain
	logic                         rx_line;     // synchronized line
	logic                         rx_prev;     // rx_line one cycle ago
	logic                         fall_edge;   // high to low on the synced line
	logic [BAUD_W-1:0]            os_cnt;      // oversample counter
	logic                         bit_mid;     // a full bit time after the last sample
	logic [IDX_W-1:0]             bit_idx;     // data bit being sampled
	uart_data_t                   data_sr;     // sipo, lsb arrives first
	logic                         par_bit;     // sampled parity bit
	logic                         exp_parity;  // parity computed over data_sr

	// input synchronizer plus edge detect flop
	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			sync_ff <= '1;  // line idles high
			rx_prev <= 1'b1;
		end else begin
			sync_ff <= {sync_ff[`UART_SYNC_STAGES-2:0], i_serial};
			rx_prev <= rx_line;
		end
	end

	assign rx_line    = sync_ff[`UART_SYNC_STAGES-1];
	assign fall_edge  = rx_prev && !rx_line;  // a held low stop bit does not retrigger
	assign bit_mid    = (os_cnt == BAUD_LAST);
	assign exp_parity = (^data_sr) ^ `UART_PARITY_ODD;

	// bit fsm with oversample counter
	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			state   <= RX_IDLE;
			os_cnt  <= '0;
			bit_idx <= '0;
		end else begin
			os_cnt <= os_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					os_cnt <= '0;
					if (fall_edge) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					if (os_cnt == HALF_LAST) begin  // middle of the start bit
						os_cnt  <= '0;
						bit_idx <= '0;
						state   <= rx_line ? RX_IDLE : RX_DATA;  // high again means a glitch
					end
				end
				RX_DATA: begin
					if (bit_mid) begin
						os_cnt  <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == DATA_LAST) begin
							state <= RX_PARITY;
						end
					end
				end
				RX_PARITY: begin
					if (bit_mid) begin
						os_cnt <= '0;
						state  <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (bit_mid) begin
						os_cnt <= '0;
						state  <= RX_IDLE;  // rest of the stop bit is spent in idle
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// payload capture at mid bit
	always_ff @(posedge i_tx_clk) begin
		if ((state == RX_DATA) && bit_mid) begin
			data_sr <= {rx_line, data_sr[`UART_DATA_WIDTH-1:1]};
		end
		if ((state == RX_PARITY) && bit_mid) begin
			par_bit <= rx_line;
		end
	end

	// result register, valid pulses at mid stop bit
	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			o_rx_result <= '0;
		end else begin
			o_rx_result.valid <= 1'b0;
			if ((state == RX_STOP) && bit_mid) begin
				o_rx_result.valid <= 1'b1;
				o_rx_result.error <= (par_bit != exp_parity) || !rx_line;  // stop must be high
				o_rx_result.data  <= data_sr;
			end
		end
	end

endmodule

`default_nettype wire

/* design/uart_tx.sv */
`default_nettype none
`timescale 1ns/100ps

`include "uart_macros.svh"

module uart_tx (
	input  logic                   i_tx_clk,
	input  logic                   i_reset_tx,
	input  uart_pkg::uart_tx_req_t i_tx_req,
	output logic                   o_serial,
	output logic                   o_busy
);

	import uart_pkg::*;

	localparam int unsigned BAUD_W = $clog2(`UART_CLOCKS_PER_BIT);  // oversample counter width
	localparam int unsigned BIT_W  = $clog2(`UART_FRAME_BITS + 1);  // bit counter width

	localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`UART_CLOCKS_PER_BIT - 1);
	localparam logic [BIT_W-1:0]  STOP_IDX  = BIT_W'(`UART_FRAME_BITS - 1);

	uart_data_t                  tx_data;      // byte offered with the request
	logic                        parity_bit;   // parity of tx_data
	logic                        start_frame;  // request accepted this cycle
	logic                        bit_done;     // last cycle of the current bit
	logic [BAUD_W-1:0]           baud_cnt;     // cycles spent in the current bit
	logic [BIT_W-1:0]            bit_cnt;      // index of the bit on the line
	logic [`UART_FRAME_BITS-1:0] frame_sr;     // piso, bit 0 drives the line

	assign tx_data     = i_tx_req.data;
	assign parity_bit  = (^tx_data) ^ `UART_PARITY_ODD;  // inverted for odd parity
	assign start_frame = i_tx_req.send && !o_busy;       // send is dropped while busy
	assign bit_done    = (baud_cnt == BAUD_LAST);

	// baud counter, restarts with every accepted frame
	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			baud_cnt <= '0;
		end else if (start_frame) begin
			baud_cnt <= '0;  // start bit begins now
		end else if (o_busy) begin
			if (bit_done) begin
				baud_cnt <= '0;
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	// bit counter, counts completed bits of the frame
	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			bit_cnt <= '0;
		end else if (start_frame) begin
			bit_cnt <= '0;
		end else if (o_busy && bit_done) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// busy covers all frame bits, back to back sends start one cycle after it drops
	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			o_busy <= 1'b0;
		end else if (start_frame) begin
			o_busy <= 1'b1;
		end else if (o_busy && bit_done && (bit_cnt == STOP_IDX)) begin
			o_busy <= 1'b0;  // end of stop bit
		end
	end

	// frame shifter, line idles high because ones are shifted in
	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			frame_sr <= '1;  // idle line
		end else if (start_frame) begin
			frame_sr <= {1'b1, parity_bit, tx_data, 1'b0};  // stop, parity, data, start
		end else if (o_busy && bit_done) begin
			frame_sr <= {1'b1, frame_sr[`UART_FRAME_BITS-1:1]};  // lsb first
		end
	end

	assign o_serial = frame_sr[0];  // straight from a flop, no glitches on the line

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -euo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f compile.f --top-module uart_loopback_tb -o uart_sim

./obj_dir/uart_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "sim failed" sim.log; then
	echo "simulation reported errors, see sim.log"
	exit 1
fi

echo "simulation clean"

/* verification/uart_loopback_assert.sv */
`default_nettype none
`timescale 1ns/100ps

module uart_loopback_assert (
	input logic                      i_tx_clk,
	input logic                      i_reset_tx,
	input logic                      i_busy,
	input logic                      i_serial,
	input uart_pkg::uart_rx_result_t i_rx_result
);

	int fail_cnt = 0;  // failed assertion count, read by the testbench at the end

	// stop bit is high, so a frame can only end on a high line
	busy_holds_on_low_line: assert property (@(posedge i_tx_clk) disable iff (i_reset_tx)
		(i_busy && !i_serial) |=> i_busy)
		else begin
			$error("busy dropped while the line was low");
			fail_cnt++;
		end

	// valid is a strobe, never two cycles in a row
	valid_single_cycle: assert property (@(posedge i_tx_clk) disable iff (i_reset_tx)
		i_rx_result.valid |=> !i_rx_result.valid)
		else begin
			$error("rx valid stayed high for more than one cycle");
			fail_cnt++;
		end

	// idle line is high
	line_high_when_idle: assert property (@(posedge i_tx_clk) disable iff (i_reset_tx)
		!i_busy |-> i_serial)
		else begin
			$error("line low while the transmitter is idle");
			fail_cnt++;
		end

endmodule

bind uart_loopback_top uart_loopback_assert u_assert (
	.i_tx_clk    (i_tx_clk),
	.i_reset_tx  (i_reset_tx),
	.i_busy      (o_busy),
	.i_serial    (o_serial_out),
	.i_rx_result (o_rx_result)
);

`default_nettype wire

/* verification/uart_loopback_tb.sv */
`default_nettype none
`timescale 1ns/100ps

`include "uart_macros.svh"

module uart_loopback_tb;

	import uart_pkg::*;

	localparam int CLK_PERIOD     = 40;                              // ns
	localparam int DATA_W         = `UART_DATA_WIDTH;
	localparam int CPB            = `UART_CLOCKS_PER_BIT;
	localparam int FRAME_BITS     = `UART_FRAME_BITS;
	localparam int FRAME_CYC      = CPB * FRAME_BITS;                // 88 cycles of busy
	localparam int RX_BOUND       = `UART_SYNC_STAGES + FRAME_CYC + 2;
	localparam int TIMEOUT_CYCLES = 6000;                            // ~40 frames plus margin

	logic            tx_clk;
	logic            reset_tx;
	uart_tx_req_t    tx_req;
	logic            loopback;
	logic            serial_in;
	logic            serial_out;
	logic            busy;
	uart_rx_result_t rx_result;

	int              errors;
	int              assert_fails;
	int              cycle_cnt;    // posedges since time zero
	int              frame_start;  // cycle_cnt when the current frame began
	logic [31:0]     rnd_state;
	uart_rx_result_t rx_q[$];      // every valid seen on the result port

	uart_loopback_top dut (
		.i_tx_clk     (tx_clk),
		.i_reset_tx   (reset_tx),
		.i_tx_req     (tx_req),
		.i_loopback   (loopback),
		.i_serial_in  (serial_in),
		.o_serial_out (serial_out),
		.o_busy       (busy),
		.o_rx_result  (rx_result)
	);

	initial begin
		tx_clk = 1'b0;
		forever #(CLK_PERIOD / 2) tx_clk = ~tx_clk;
	end

	// sees pre-edge values, so a result lands in rx_q one cycle after valid
	always @(posedge tx_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (!reset_tx && rx_result.valid) begin
			rx_q.push_back(rx_result);
		end
	end

	initial begin : watchdog
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("timeout: tests still running after %0d cycles", cycle_cnt);
		$display("sim failed");
		$finish;
	end

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// expected parity from the data bits and the odd flag
	function automatic logic parity_of(input uart_data_t data);
		uart_data_t rest;
		logic       p;
		rest = data;
		p    = `UART_PARITY_ODD;
		for (int i = 0; i < DATA_W; i++) begin
			p    = p ^ rest[0];
			rest = rest >> 1;
		end
		return p;
	endfunction

	// bit idx of a frame in line order
	function automatic logic frame_bit(input uart_data_t data, input int idx);
		uart_data_t shifted;
		logic       bit_val;
		if (idx == 0) begin
			bit_val = 1'b0;  // start
		end else if (idx <= DATA_W) begin
			shifted = data >> (idx - 1);
			bit_val = shifted[0];
		end else if (idx == DATA_W + 1) begin
			bit_val = parity_of(data);
		end else begin
			bit_val = 1'b1;  // stop
		end
		return bit_val;
	endfunction

	task automatic log_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		errors++;
		$display("error %s: expected %0h, actual %0h", name, expected, actual);
	endtask

	task automatic flag_problem(input string msg);
		errors++;
		$display("error: %s", msg);
	endtask

	// called on a negedge with busy low and returns one cycle into the start bit
	task automatic send_byte(input string name, input uart_data_t data);
		tx_req.send = 1'b1;
		tx_req.data = data;
		@(negedge tx_clk);
		tx_req.send = 1'b0;
		frame_start = cycle_cnt;
		if (busy !== 1'b1) begin
			flag_problem({name, ": send request was not accepted"});
		end
	endtask

	task automatic wait_busy_low(input string name);
		while (busy === 1'b1 && (cycle_cnt - frame_start) <= FRAME_CYC + CPB) begin
			@(negedge tx_clk);
		end
		if (busy !== 1'b0) begin
			flag_problem({name, ": busy still high after a full frame"});
		end else if ((cycle_cnt - frame_start) != FRAME_CYC) begin
			log_mismatch({name, " busy cycles"}, FRAME_CYC, cycle_cnt - frame_start);
		end
	endtask

	task automatic expect_rx(input string name, input uart_data_t exp_data, input logic exp_err);
		uart_rx_result_t res;
		while (rx_q.size() == 0 && (cycle_cnt - frame_start) <= RX_BOUND) begin
			@(negedge tx_clk);
		end
		if (rx_q.size() == 0) begin
			flag_problem($sformatf("%s: no valid within %0d cycles", name, RX_BOUND));
		end else begin
			res = rx_q.pop_front();
			if (res.data !== exp_data) begin
				log_mismatch({name, " data"}, 32'(exp_data), 32'(res.data));
			end
			if (res.error !== exp_err) begin
				log_mismatch({name, " error flag"}, 32'(exp_err), 32'(res.error));
			end
		end
	endtask

	// drives one frame on the external line with stop level and parity set by the caller
	task automatic drive_frame(input uart_data_t data, input logic flip_parity,
			input logic stop_bit);
		logic [FRAME_BITS-1:0] bits;
		bits        = {stop_bit, parity_of(data) ^ flip_parity, data, 1'b0};
		frame_start = cycle_cnt;
		for (int i = 0; i < FRAME_BITS; i++) begin
			serial_in = bits[0];
			repeat (CPB) @(negedge tx_clk);
			bits = bits >> 1;
		end
		serial_in = 1'b1;  // back to idle
	endtask

	task automatic idle_after_reset();
		for (int i = 0; i < 20; i++) begin
			@(negedge tx_clk);
			if (busy !== 1'b0) begin
				log_mismatch("idle busy", 0, 32'(busy));
			end
			if (serial_out !== 1'b1) begin
				log_mismatch("idle line", 1, 32'(serial_out));
			end
			if (rx_result.valid !== 1'b0) begin
				log_mismatch("idle valid", 0, 32'(rx_result.valid));
			end
		end
	endtask

	task automatic check_frame_shape(input uart_data_t data);
		logic [FRAME_BITS-1:0] seen;
		logic [FRAME_BITS-1:0] expected;
		seen     = '0;
		expected = '0;
		for (int i = 0; i < FRAME_BITS; i++) begin
			expected = {frame_bit(data, i), expected[FRAME_BITS-1:1]};  // lsb is first on line
		end
		loopback = 1'b1;
		send_byte("frame_shape", data);
		while (busy === 1'b1 && (cycle_cnt - frame_start) <= FRAME_CYC + CPB) begin
			if ((cycle_cnt - frame_start) % CPB == CPB / 2) begin
				seen = {serial_out, seen[FRAME_BITS-1:1]};  // mid bit sample
			end
			@(negedge tx_clk);
		end
		wait_busy_low("frame_shape");
		if (seen !== expected) begin
			log_mismatch("frame_shape bits", 32'(expected), 32'(seen));
		end
	endtask

	task automatic loopback_receive(input uart_data_t data);
		expect_rx("loopback_rx", data, 1'b0);
	endtask

	task automatic ignore_send_while_busy(input uart_data_t first, input uart_data_t second);
		loopback = 1'b1;
		send_byte("busy_ignore", first);
		repeat (FRAME_CYC / 2) @(negedge tx_clk);
		tx_req.send = 1'b1;  // mid frame request that must be dropped
		tx_req.data = second;
		@(negedge tx_clk);
		tx_req.send = 1'b0;
		wait_busy_low("busy_ignore");
		repeat (2 * CPB) begin
			@(negedge tx_clk);
			if (busy !== 1'b0) begin
				flag_problem("busy_ignore: request sent while busy started a frame");
			end
		end
		expect_rx("busy_ignore", first, 1'b0);
		repeat (FRAME_CYC) @(negedge tx_clk);
		if (rx_q.size() != 0) begin
			log_mismatch("busy_ignore extra valids", 0, rx_q.size());
		end
	endtask

	task automatic external_frames();
		loopback  = 1'b0;
		serial_in = 1'b1;
		repeat (2 * CPB) @(negedge tx_clk);
		drive_frame(8'h5B, 1'b0, 1'b1);
		expect_rx("ext_good", 8'h5B, 1'b0);
		repeat (2 * CPB) @(negedge tx_clk);
		drive_frame(8'h96, 1'b1, 1'b1);
		expect_rx("ext_parity", 8'h96, 1'b1);
		repeat (2 * CPB) @(negedge tx_clk);
		drive_frame(8'h0F, 1'b0, 1'b0);
		expect_rx("ext_stop", 8'h0F, 1'b1);
		repeat (2 * CPB) @(negedge tx_clk);
	endtask

	task automatic random_burst();
		uart_data_t      sent_q[$];
		uart_data_t      byte_val;
		uart_rx_result_t res;
		loopback = 1'b1;
		for (int i = 0; i < 16; i++) begin
			rnd_state = next_random(rnd_state);
			byte_val  = rnd_state[DATA_W-1:0];
			sent_q.push_back(byte_val);
			send_byte("random_burst", byte_val);  // first negedge that sees busy low
			wait_busy_low("random_burst");
		end
		while (rx_q.size() < 16 && (cycle_cnt - frame_start) <= RX_BOUND + 1) begin
			@(negedge tx_clk);
		end
		repeat (FRAME_CYC) @(negedge tx_clk);
		if (rx_q.size() != 16) begin
			log_mismatch("random_burst valid count", 16, rx_q.size());
		end
		while (rx_q.size() != 0 && sent_q.size() != 0) begin
			res      = rx_q.pop_front();
			byte_val = sent_q.pop_front();
			if (res.data !== byte_val || res.error !== 1'b0) begin
				log_mismatch("random_burst result", 32'({1'b0, byte_val}),
						32'({res.error, res.data}));
			end
		end
	endtask

	initial begin
		tx_req      = '0;
		loopback    = 1'b1;
		serial_in   = 1'b1;
		reset_tx    = 1'b1;
		errors      = 0;
		frame_start = 0;
		rnd_state   = 32'd92645;
		repeat (5) @(negedge tx_clk);
		reset_tx = 1'b0;
		idle_after_reset();
		check_frame_shape(8'hA5);
		loopback_receive(8'hA5);
		ignore_send_while_busy(8'h3C, 8'hC3);
		external_frames();
		random_burst();
		assert_fails = dut.u_assert.fail_cnt;
		$display("closing: %0d check errors, %0d assertion failures", errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
